//--- verilog.f
+incdir+test
rtl/mipsPkg.sv
rtl/mainDecoder.sv
rtl/aluDecoder.sv
rtl/regFile.sv
rtl/pipeReg.sv
rtl/decodeStage.sv
test/tbDecodeStage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbDecodeStage
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
SIM       ?= $(BUILD_DIR)/V$(TOP)

SOURCES := $(wildcard rtl/*.sv test/*.sv test/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- test/decodeModel.svh
`ifndef decodeModelSvh
`define decodeModelSvh

logic [31:0]   shadowRegs [32];	// register file as the model sees it
mipsPkg::execT expQueue [$];
logic          idValidM;		// model copy of the IF/ID stage
logic [31:0]   idPcM;
logic [31:0]   idInstrM;
logic          expValidM;		// ID/EX valid as the model sees it

task automatic resetModel();
	foreach (shadowRegs[i])
		shadowRegs[i] = '0;
	expQueue.delete();
	idValidM  = 1'b0;
	idPcM     = '0;
	idInstrM  = '0;
	expValidM = 1'b0;
endtask

// control bundle straight from the instruction encoding
function automatic mipsPkg::ctrlT expectCtrl(input logic [31:0] instr);
	mipsPkg::ctrlT c;
	logic [5:0]    op;
	logic [5:0]    fn;
	op = instr[31:26];
	fn = instr[5:0];
	c = '0;
	c.regDst   = mipsPkg::dstRd;
	c.aluClass = mipsPkg::clsNone;
	c.signExt  = !(op inside {mipsPkg::opAndi, mipsPkg::opOri, mipsPkg::opXori});
	if (op == mipsPkg::opRType) begin
		c.syscall   = (fn == mipsPkg::fnSyscall);
		c.brk       = (fn == mipsPkg::fnBreak);
		c.hiloToReg = fn inside {mipsPkg::fnMfhi, mipsPkg::fnMflo};
		c.hiloWen   = fn inside {mipsPkg::fnMthi, mipsPkg::fnMtlo, mipsPkg::fnMult,
			mipsPkg::fnMultu, mipsPkg::fnDiv, mipsPkg::fnDivu};
		c.ri = !(c.syscall || c.brk || c.hiloToReg || c.hiloWen || fn inside {
			mipsPkg::fnAdd, mipsPkg::fnAddu, mipsPkg::fnSub, mipsPkg::fnSubu,
			mipsPkg::fnAnd, mipsPkg::fnOr, mipsPkg::fnXor, mipsPkg::fnNor,
			mipsPkg::fnSlt, mipsPkg::fnSltu, mipsPkg::fnSll, mipsPkg::fnSrl,
			mipsPkg::fnSra, mipsPkg::fnSllv, mipsPkg::fnSrlv, mipsPkg::fnSrav,
			mipsPkg::fnJr, mipsPkg::fnJalr});
		if (!(c.ri || c.syscall || c.brk)) begin
			c.aluClass = mipsPkg::clsRType;
			c.regWrite = !(c.hiloWen || fn == mipsPkg::fnJr);
		end
	end else if (op[5:3] == 3'b001) begin	// immediate ALU group
		c.regWrite = 1'b1;
		c.regDst   = mipsPkg::dstRt;
		c.isImm    = 1'b1;
		case (op[2:0])
			3'd0: c.aluClass = mipsPkg::clsAddi;
			3'd1: c.aluClass = mipsPkg::clsAddiu;
			3'd2: c.aluClass = mipsPkg::clsSlti;
			3'd3: c.aluClass = mipsPkg::clsSltiu;
			3'd4: c.aluClass = mipsPkg::clsAndi;
			3'd5: c.aluClass = mipsPkg::clsOri;
			3'd6: c.aluClass = mipsPkg::clsXori;
			default: c.aluClass = mipsPkg::clsLui;
		endcase
	end else if (op inside {mipsPkg::opLb, mipsPkg::opLh, mipsPkg::opLw, mipsPkg::opLbu,
		mipsPkg::opLhu}) begin
		c.regWrite = 1'b1;
		c.regDst   = mipsPkg::dstRt;
		c.isImm    = 1'b1;
		c.memRead  = 1'b1;
		c.memToReg = 1'b1;
		c.aluClass = mipsPkg::clsMem;
	end else if (op inside {mipsPkg::opSb, mipsPkg::opSh, mipsPkg::opSw}) begin
		c.isImm    = 1'b1;
		c.memWrite = 1'b1;
		c.aluClass = mipsPkg::clsMem;
	end else if (op == mipsPkg::opRegimm && instr[19:17] != 3'b000) begin
		c.ri = 1'b1;	// rt outside the four branch codes
	end else if (op == mipsPkg::opJal || op == mipsPkg::opRegimm && instr[20]) begin
		c.regWrite = 1'b1;
		c.regDst   = mipsPkg::dstRa;
	end else if (op == mipsPkg::opCop0) begin
		case (instr[25:21])
			mipsPkg::rsMtc0: begin
				c.cp0Wen   = 1'b1;
				c.aluClass = mipsPkg::clsMtc0;
			end
			mipsPkg::rsMfc0: begin
				c.regWrite = 1'b1;
				c.regDst   = mipsPkg::dstRt;
				c.cp0ToReg = 1'b1;
				c.aluClass = mipsPkg::clsMfc0;
			end
			default: begin
				c.eret = (instr == mipsPkg::eretWord);
				c.ri   = !c.eret;
			end
		endcase
	end else if (!(op inside {mipsPkg::opJ, mipsPkg::opBeq, mipsPkg::opBne, mipsPkg::opBlez,
		mipsPkg::opBgtz, mipsPkg::opRegimm})) begin
		c.ri = 1'b1;
	end
	return c;
endfunction

function automatic mipsPkg::aluCtrlE expectAlu(input mipsPkg::aluClassE cls,
	input logic [5:0] fn);
	case (cls)
		mipsPkg::clsAddi, mipsPkg::clsMem: return mipsPkg::aluAdd;
		mipsPkg::clsAddiu: return mipsPkg::aluAddu;
		mipsPkg::clsSlti:  return mipsPkg::aluSlt;
		mipsPkg::clsSltiu: return mipsPkg::aluSltu;
		mipsPkg::clsAndi:  return mipsPkg::aluAnd;
		mipsPkg::clsOri:   return mipsPkg::aluOr;
		mipsPkg::clsXori:  return mipsPkg::aluXor;
		mipsPkg::clsLui:   return mipsPkg::aluLui;
		mipsPkg::clsMtc0, mipsPkg::clsMfc0: return mipsPkg::aluPassB;
		mipsPkg::clsRType: ;
		default: return mipsPkg::aluNone;
	endcase
	case (fn)	// R-type by funct
		mipsPkg::fnAdd:  return mipsPkg::aluAdd;
		mipsPkg::fnAddu: return mipsPkg::aluAddu;
		mipsPkg::fnSub:  return mipsPkg::aluSub;
		mipsPkg::fnSubu: return mipsPkg::aluSubu;
		mipsPkg::fnAnd:  return mipsPkg::aluAnd;
		mipsPkg::fnOr:   return mipsPkg::aluOr;
		mipsPkg::fnXor:  return mipsPkg::aluXor;
		mipsPkg::fnNor:  return mipsPkg::aluNor;
		mipsPkg::fnSlt:  return mipsPkg::aluSlt;
		mipsPkg::fnSltu: return mipsPkg::aluSltu;
		mipsPkg::fnSll, mipsPkg::fnSllv: return mipsPkg::aluSll;
		mipsPkg::fnSrl, mipsPkg::fnSrlv: return mipsPkg::aluSrl;
		mipsPkg::fnSra, mipsPkg::fnSrav: return mipsPkg::aluSra;
		mipsPkg::fnMfhi, mipsPkg::fnMflo: return mipsPkg::aluPassB;
		default: return mipsPkg::aluNone;
	endcase
endfunction

function automatic logic [31:0] readShadow(input logic [4:0] addr);
	if (addr == 5'd0)
		return '0;
	if (wbWen && wbAddr == addr)
		return wbData;	// write in the same cycle passes through
	return shadowRegs[addr];
endfunction

function automatic mipsPkg::execT buildExpected(input logic [31:0] pc, input logic [31:0] instr);
	mipsPkg::execT e;
	e.pc      = pc;
	e.ctrl    = expectCtrl(instr);
	e.aluCtrl = expectAlu(e.ctrl.aluClass, instr[5:0]);
	e.rs      = instr[25:21];
	e.rt      = instr[20:16];
	e.rsData  = readShadow(e.rs);
	e.rtData  = readShadow(e.rt);
	e.imm     = e.ctrl.signExt ? {{16{instr[15]}}, instr[15:0]} : {16'b0, instr[15:0]};
	e.shamt   = instr[10:6];
	case (e.ctrl.regDst)
		mipsPkg::dstRt: e.destReg = e.rt;
		mipsPkg::dstRa: e.destReg = 5'(mipsPkg::linkReg);
		default:        e.destReg = instr[15:11];
	endcase
	return e;
endfunction

// one rising edge, called before the new inputs are driven
task automatic modelStep();
	expValidM = idValidM;	// IF/ID content moves on to ID/EX
	if (idValidM)
		expQueue.push_back(buildExpected(idPcM, idInstrM));
	if (wbWen && wbAddr != 5'd0)
		shadowRegs[wbAddr] = wbData;
	idValidM = inValid;
	idPcM    = inPc;
	idInstrM = inInstr;
endtask

`endif

//--- test/tbDecodeStage.sv
`timescale 1ns/1ps

module tbDecodeStage;

	localparam int strobeCycles = 3000;
	localparam int resetCycles  = 8;
	localparam int cycleLimit   = strobeCycles + resetCycles + 2 + 100;	// latency plus margin

	localparam logic [5:0] legalOps [25] = '{6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06,
		6'h07, 6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h10, 6'h20, 6'h21,
		6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b};
	localparam logic [5:0] legalFuncts [28] = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07,
		6'h08, 6'h09, 6'h0c, 6'h0d, 6'h10, 6'h11, 6'h12, 6'h13, 6'h18, 6'h19, 6'h1a, 6'h1b,
		6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};

	logic          clk;
	logic          arstN;
	logic          inValid;
	logic [31:0]   inPc;
	logic [31:0]   inInstr;
	logic          wbWen;
	logic [4:0]    wbAddr;
	logic [31:0]   wbData;
	logic          exValid;
	mipsPkg::execT exOut;
	int            cycleCount = 0;
	int            checkedCount = 0;

	`include "decodeModel.svh"

	decodeStage DUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic stopRun(input string reason);
		$display("%s", reason);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic checkEqual(input string testName, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected)
			stopRun($sformatf("Mismatch %s expected 0x%0h actual 0x%0h", testName, expected,
				actual));
	endtask

	task automatic checkBundle(input mipsPkg::execT want);
		string tag;
		tag = $sformatf("strobe%0d", checkedCount);
		checkEqual({tag, " pc"}, 64'(want.pc), 64'(exOut.pc));
		checkEqual({tag, " ctrl"}, 64'(want.ctrl), 64'(exOut.ctrl));
		checkEqual({tag, " aluCtrl"}, 64'(want.aluCtrl), 64'(exOut.aluCtrl));
		checkEqual({tag, " rsData"}, 64'(want.rsData), 64'(exOut.rsData));
		checkEqual({tag, " rtData"}, 64'(want.rtData), 64'(exOut.rtData));
		checkEqual({tag, " imm"}, 64'(want.imm), 64'(exOut.imm));
		checkEqual({tag, " shamt"}, 64'(want.shamt), 64'(exOut.shamt));
		checkEqual({tag, " rs"}, 64'(want.rs), 64'(exOut.rs));
		checkEqual({tag, " rt"}, 64'(want.rt), 64'(exOut.rt));
		checkEqual({tag, " destReg"}, 64'(want.destReg), 64'(exOut.destReg));
		checkedCount++;
	endtask

	// mostly legal encodings with random register fields, some raw words
	function automatic logic [31:0] randomInstr();
		logic [31:0] w;
		w = $urandom;
		if ($urandom_range(99) >= 80)
			return w;
		w[31:26] = legalOps[$urandom_range(24)];
		if (w[31:26] == 6'h00)
			w[5:0] = legalFuncts[$urandom_range(27)];
		if (w[31:26] == 6'h01)
			w[19:17] = 3'b000;	// bltz, bgez and the link forms
		if (w[31:26] == 6'h10) begin
			w[25:21] = ($urandom_range(1) == 1) ? 5'h04 : 5'h00;
			w[10:0]  = '0;
		end
		if ($urandom_range(19) == 0)
			w = mipsPkg::eretWord;
		return w;
	endfunction

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
			stopRun($sformatf("timeout, no end of run after %0d cycles", cycleCount));
	end

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		if (arstN) begin
			checkEqual("exValid", 64'(expValidM), 64'(exValid));	// exact two-cycle latency
			if (exValid) begin
				if (expQueue.size() == 0)
					stopRun("exValid went high with no instruction in flight");
				else
					checkBundle(expQueue.pop_front());
			end
		end
	end

	initial begin
		void'($urandom(32'h77b2bb3a));
		resetModel();
		arstN   = 1'b0;
		inValid = 1'b0;
		inPc    = '0;
		inInstr = '0;
		wbWen   = 1'b0;
		wbAddr  = '0;
		wbData  = '0;
		repeat (resetCycles) @(posedge clk);
		arstN <= 1'b1;
		repeat (strobeCycles) begin
			@(posedge clk);
			modelStep();
			inValid <= ($urandom_range(99) < 70);
			inPc    <= {30'($urandom), 2'b00};
			inInstr <= randomInstr();
			wbWen   <= ($urandom_range(1) == 1);
			wbAddr  <= 5'($urandom);
			wbData  <= $urandom;
		end
		repeat (3) begin	// drain both stages
			@(posedge clk);
			modelStep();
			inValid <= 1'b0;
			wbWen   <= 1'b0;
		end
		@(negedge clk);
		if (expQueue.size() != 0) begin
			stopRun($sformatf("%0d instructions never came out", expQueue.size()));
		end else begin
			$display("checked %0d instructions", checkedCount);
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

//--- rtl/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
	input  logic          clk,
	input  logic          arstN,
	input  logic          inValid,
	input  logic [31:0]   inPc,
	input  logic [31:0]   inInstr,
	input  logic          wbWen,
	input  logic [4:0]    wbAddr,
	input  logic [31:0]   wbData,
	output logic          exValid,
	output mipsPkg::execT exOut
);

	mipsPkg::fetchT   fetchIn;
	mipsPkg::fetchT   fetchOut;
	logic             idValid;
	mipsPkg::ctrlT    ctrl;
	mipsPkg::aluCtrlE aluCtrl;
	logic [31:0]      rsData;
	logic [31:0]      rtData;
	logic [4:0]       rs;
	logic [4:0]       rt;
	logic [4:0]       rd;
	logic [31:0]      imm;
	logic [4:0]       destReg;
	mipsPkg::execT    execIn;

	assign fetchIn = '{pc: inPc, instr: inInstr};

	pipeReg #(.T(mipsPkg::fetchT)) ifId (
		.clk(clk), .arstN(arstN),
		.inValid(inValid), .inData(fetchIn),
		.outValid(idValid), .outData(fetchOut)
	);

	assign rs = fetchOut.instr[25:21];
	assign rt = fetchOut.instr[20:16];
	assign rd = fetchOut.instr[15:11];

	mainDecoder mainDec (.instr(fetchOut.instr), .ctrl(ctrl));

	aluDecoder aluDec (
		.aluClass(ctrl.aluClass),
		.funct(mipsPkg::functE'(fetchOut.instr[5:0])),
		.aluCtrl(aluCtrl)
	);

	regFile regs (
		.clk(clk), .arstN(arstN),
		.wen(wbWen), .waddr(wbAddr), .wdata(wbData),
		.raddrA(rs), .rdataA(rsData),
		.raddrB(rt), .rdataB(rtData)
	);

	// lui keeps the raw immediate, shifted up in execute
	assign imm = ctrl.signExt ? {{16{fetchOut.instr[15]}}, fetchOut.instr[15:0]}
		: {16'b0, fetchOut.instr[15:0]};

	always_comb begin
		case (ctrl.regDst)
			mipsPkg::dstRt: destReg = rt;
			mipsPkg::dstRa: destReg = 5'(mipsPkg::linkReg);
			default:        destReg = rd;
		endcase
	end

	always_comb begin
		execIn.pc      = fetchOut.pc;
		execIn.ctrl    = ctrl;
		execIn.aluCtrl = aluCtrl;
		execIn.rsData  = rsData;
		execIn.rtData  = rtData;
		execIn.imm     = imm;
		execIn.shamt   = fetchOut.instr[10:6];
		execIn.rs      = rs;
		execIn.rt      = rt;
		execIn.destReg = destReg;
	end

	pipeReg #(.T(mipsPkg::execT)) idEx (
		.clk(clk), .arstN(arstN),
		.inValid(idValid), .inData(execIn),
		.outValid(exValid), .outData(exOut)
	);

endmodule

//--- rtl/pipeReg.sv
`timescale 1ns/1ps

module pipeReg #(
	parameter type T = logic
) (
	input  logic clk,
	input  logic arstN,
	input  logic inValid,
	input  T     inData,
	output logic outValid,
	output T     outData
);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= inValid;
		end
	end

	// payload follows every edge, qualified downstream by outValid
	always_ff @(posedge clk) begin
		outData <= inData;
	end

	validKnown: assert property (@(posedge clk) disable iff (!arstN)
		!$isunknown(outValid));

endmodule

//--- rtl/regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic        clk,
	input  logic        arstN,
	input  logic        wen,
	input  logic [4:0]  waddr,
	input  logic [31:0] wdata,
	input  logic [4:0]  raddrA,
	output logic [31:0] rdataA,
	input  logic [4:0]  raddrB,
	output logic [31:0] rdataB
);

	logic [31:0] regs [mipsPkg::regCount];
	logic        bypassA;
	logic        bypassB;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < mipsPkg::regCount; i++)
				regs[i] <= '0;
		end else if (wen && waddr != 5'd0) begin	// $zero never written
			regs[waddr] <= wdata;
		end
	end

	// a write landing at the next edge is already visible to the readers
	assign bypassA = wen && waddr != 5'd0 && waddr == raddrA;
	assign bypassB = wen && waddr != 5'd0 && waddr == raddrB;

	assign rdataA = bypassA ? wdata : regs[raddrA];
	assign rdataB = bypassB ? wdata : regs[raddrB];

	zeroReadA: assert property (@(posedge clk) disable iff (!arstN)
		raddrA == 5'd0 |-> rdataA == '0);
	zeroReadB: assert property (@(posedge clk) disable iff (!arstN)
		raddrB == 5'd0 |-> rdataB == '0);

endmodule

//--- rtl/aluDecoder.sv
`timescale 1ns/1ps

module aluDecoder (
	input  mipsPkg::aluClassE aluClass,
	input  mipsPkg::functE    funct,
	output mipsPkg::aluCtrlE  aluCtrl
);

	mipsPkg::aluCtrlE rTypeCtrl;

	// variable shifts share the fixed shift codes
	// execute tells them apart by imm[2], which carries funct bit 2
	always_comb begin
		case (funct)
			mipsPkg::fnAdd:  rTypeCtrl = mipsPkg::aluAdd;
			mipsPkg::fnAddu: rTypeCtrl = mipsPkg::aluAddu;
			mipsPkg::fnSub:  rTypeCtrl = mipsPkg::aluSub;
			mipsPkg::fnSubu: rTypeCtrl = mipsPkg::aluSubu;
			mipsPkg::fnAnd:  rTypeCtrl = mipsPkg::aluAnd;
			mipsPkg::fnOr:   rTypeCtrl = mipsPkg::aluOr;
			mipsPkg::fnXor:  rTypeCtrl = mipsPkg::aluXor;
			mipsPkg::fnNor:  rTypeCtrl = mipsPkg::aluNor;
			mipsPkg::fnSlt:  rTypeCtrl = mipsPkg::aluSlt;
			mipsPkg::fnSltu: rTypeCtrl = mipsPkg::aluSltu;
			mipsPkg::fnSll, mipsPkg::fnSllv:
				rTypeCtrl = mipsPkg::aluSll;
			mipsPkg::fnSrl, mipsPkg::fnSrlv:
				rTypeCtrl = mipsPkg::aluSrl;
			mipsPkg::fnSra, mipsPkg::fnSrav:
				rTypeCtrl = mipsPkg::aluSra;
			mipsPkg::fnMfhi, mipsPkg::fnMflo:
				rTypeCtrl = mipsPkg::aluPassB;	// hilo value muxed in later
			default:
				rTypeCtrl = mipsPkg::aluNone;	// jr, mult/div, hilo writes
		endcase
	end

	always_comb begin
		case (aluClass)
			mipsPkg::clsRType: aluCtrl = rTypeCtrl;
			mipsPkg::clsAddi:  aluCtrl = mipsPkg::aluAdd;
			mipsPkg::clsAddiu: aluCtrl = mipsPkg::aluAddu;
			mipsPkg::clsSlti:  aluCtrl = mipsPkg::aluSlt;
			mipsPkg::clsSltiu: aluCtrl = mipsPkg::aluSltu;
			mipsPkg::clsAndi:  aluCtrl = mipsPkg::aluAnd;
			mipsPkg::clsOri:   aluCtrl = mipsPkg::aluOr;
			mipsPkg::clsXori:  aluCtrl = mipsPkg::aluXor;
			mipsPkg::clsLui:   aluCtrl = mipsPkg::aluLui;
			mipsPkg::clsMem:   aluCtrl = mipsPkg::aluAdd;	// base + offset
			// cp0 moves carry rt straight through
			mipsPkg::clsMtc0, mipsPkg::clsMfc0:
				aluCtrl = mipsPkg::aluPassB;
			default:
				aluCtrl = mipsPkg::aluNone;
		endcase
	end

endmodule

//--- rtl/mainDecoder.sv
`timescale 1ns/1ps

module mainDecoder (
	input  logic [31:0]     instr,
	output mipsPkg::ctrlT   ctrl
);

	mipsPkg::opcodeE op;
	mipsPkg::functE  funct;
	logic [4:0]      rs;
	logic [4:0]      rt;
	logic            isEret;

	assign op     = mipsPkg::opcodeE'(instr[31:26]);
	assign funct  = mipsPkg::functE'(instr[5:0]);
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign isEret = (instr == mipsPkg::eretWord);	// whole word must match

	always_comb begin
		ctrl          = '0;
		ctrl.regDst   = mipsPkg::dstRd;
		ctrl.aluClass = mipsPkg::clsNone;
		// zero extension only for the logical immediates
		ctrl.signExt  = !(op inside {mipsPkg::opAndi, mipsPkg::opOri, mipsPkg::opXori});

		case (op)
			mipsPkg::opRType: begin
				case (funct)
					mipsPkg::fnAdd, mipsPkg::fnAddu, mipsPkg::fnSub, mipsPkg::fnSubu,
					mipsPkg::fnAnd, mipsPkg::fnOr, mipsPkg::fnXor, mipsPkg::fnNor,
					mipsPkg::fnSlt, mipsPkg::fnSltu, mipsPkg::fnSll, mipsPkg::fnSrl,
					mipsPkg::fnSra, mipsPkg::fnSllv, mipsPkg::fnSrlv, mipsPkg::fnSrav: begin
						ctrl.regWrite = 1'b1;
						ctrl.aluClass = mipsPkg::clsRType;
					end
					mipsPkg::fnMfhi, mipsPkg::fnMflo: begin
						ctrl.regWrite  = 1'b1;
						ctrl.hiloToReg = 1'b1;
						ctrl.aluClass  = mipsPkg::clsRType;
					end
					mipsPkg::fnMthi, mipsPkg::fnMtlo, mipsPkg::fnMult, mipsPkg::fnMultu,
					mipsPkg::fnDiv, mipsPkg::fnDivu: begin
						ctrl.hiloWen  = 1'b1;	// mul/div unit owns the result
						ctrl.aluClass = mipsPkg::clsRType;
					end
					mipsPkg::fnJr:
						ctrl.aluClass = mipsPkg::clsRType;
					mipsPkg::fnJalr: begin
						ctrl.regWrite = 1'b1;	// link goes to rd
						ctrl.aluClass = mipsPkg::clsRType;
					end
					mipsPkg::fnSyscall:
						ctrl.syscall = 1'b1;
					mipsPkg::fnBreak:
						ctrl.brk = 1'b1;
					default:
						ctrl.ri = 1'b1;
				endcase
			end

			mipsPkg::opAddi, mipsPkg::opAddiu, mipsPkg::opSlti, mipsPkg::opSltiu,
			mipsPkg::opAndi, mipsPkg::opOri, mipsPkg::opXori, mipsPkg::opLui: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst   = mipsPkg::dstRt;
				ctrl.isImm    = 1'b1;
				case (op)
					mipsPkg::opAddi:  ctrl.aluClass = mipsPkg::clsAddi;
					mipsPkg::opAddiu: ctrl.aluClass = mipsPkg::clsAddiu;
					mipsPkg::opSlti:  ctrl.aluClass = mipsPkg::clsSlti;
					mipsPkg::opSltiu: ctrl.aluClass = mipsPkg::clsSltiu;
					mipsPkg::opAndi:  ctrl.aluClass = mipsPkg::clsAndi;
					mipsPkg::opOri:   ctrl.aluClass = mipsPkg::clsOri;
					mipsPkg::opXori:  ctrl.aluClass = mipsPkg::clsXori;
					default:          ctrl.aluClass = mipsPkg::clsLui;
				endcase
			end

			mipsPkg::opLb, mipsPkg::opLh, mipsPkg::opLw, mipsPkg::opLbu,
			mipsPkg::opLhu: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst   = mipsPkg::dstRt;
				ctrl.isImm    = 1'b1;
				ctrl.memRead  = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluClass = mipsPkg::clsMem;
			end

			mipsPkg::opSb, mipsPkg::opSh, mipsPkg::opSw: begin
				ctrl.isImm    = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.aluClass = mipsPkg::clsMem;
			end

			// compare happens in execute, nothing to write
			mipsPkg::opBeq, mipsPkg::opBne, mipsPkg::opBlez, mipsPkg::opBgtz,
			mipsPkg::opJ: ;

			mipsPkg::opRegimm: begin
				case (rt)
					mipsPkg::rtBltz, mipsPkg::rtBgez: ;
					mipsPkg::rtBltzal, mipsPkg::rtBgezal: begin
						ctrl.regWrite = 1'b1;
						ctrl.regDst   = mipsPkg::dstRa;
					end
					default:
						ctrl.ri = 1'b1;
				endcase
			end

			mipsPkg::opJal: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst   = mipsPkg::dstRa;
			end

			mipsPkg::opCop0: begin
				case (rs)
					mipsPkg::rsMtc0: begin
						ctrl.cp0Wen   = 1'b1;	// gpr rt into cp0 rd
						ctrl.aluClass = mipsPkg::clsMtc0;
					end
					mipsPkg::rsMfc0: begin
						ctrl.regWrite = 1'b1;
						ctrl.regDst   = mipsPkg::dstRt;
						ctrl.cp0ToReg = 1'b1;
						ctrl.aluClass = mipsPkg::clsMfc0;
					end
					mipsPkg::rsEret: begin
						ctrl.eret = isEret;
						ctrl.ri   = !isEret;
					end
					default:
						ctrl.ri = 1'b1;
				endcase
			end

			default:
				ctrl.ri = 1'b1;
		endcase
	end

endmodule

//--- rtl/mipsPkg.sv
package mipsPkg;

	localparam int regCount = 32;
	localparam int linkReg = 31;	// $ra for JAL and the link branches

	// primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		opRType  = 6'b000000,
		opRegimm = 6'b000001,
		opJ      = 6'b000010,
		opJal    = 6'b000011,
		opBeq    = 6'b000100,
		opBne    = 6'b000101,
		opBlez   = 6'b000110,
		opBgtz   = 6'b000111,
		opAddi   = 6'b001000,
		opAddiu  = 6'b001001,
		opSlti   = 6'b001010,
		opSltiu  = 6'b001011,
		opAndi   = 6'b001100,
		opOri    = 6'b001101,
		opXori   = 6'b001110,
		opLui    = 6'b001111,
		opCop0   = 6'b010000,
		opLb     = 6'b100000,
		opLh     = 6'b100001,
		opLw     = 6'b100011,
		opLbu    = 6'b100100,
		opLhu    = 6'b100101,
		opSb     = 6'b101000,
		opSh     = 6'b101001,
		opSw     = 6'b101011
	} opcodeE;

	// R-type funct, instr[5:0]
	typedef enum logic [5:0] {
		fnSll     = 6'b000000,
		fnSrl     = 6'b000010,
		fnSra     = 6'b000011,
		fnSllv    = 6'b000100,
		fnSrlv    = 6'b000110,
		fnSrav    = 6'b000111,
		fnJr      = 6'b001000,
		fnJalr    = 6'b001001,
		fnSyscall = 6'b001100,
		fnBreak   = 6'b001101,
		fnMfhi    = 6'b010000,
		fnMthi    = 6'b010001,
		fnMflo    = 6'b010010,
		fnMtlo    = 6'b010011,
		fnMult    = 6'b011000,
		fnMultu   = 6'b011001,
		fnDiv     = 6'b011010,
		fnDivu    = 6'b011011,
		fnAdd     = 6'b100000,
		fnAddu    = 6'b100001,
		fnSub     = 6'b100010,
		fnSubu    = 6'b100011,
		fnAnd     = 6'b100100,
		fnOr      = 6'b100101,
		fnXor     = 6'b100110,
		fnNor     = 6'b100111,
		fnSlt     = 6'b101010,
		fnSltu    = 6'b101011
	} functE;

	// COP0 group, selected by rs
	localparam logic [4:0] rsMfc0 = 5'b00000;
	localparam logic [4:0] rsMtc0 = 5'b00100;
	localparam logic [4:0] rsEret = 5'b10000;	// CO bit set
	localparam logic [31:0] eretWord = 32'h4200_0018;

	// REGIMM group, selected by rt
	localparam logic [4:0] rtBltz   = 5'b00000;
	localparam logic [4:0] rtBgez   = 5'b00001;
	localparam logic [4:0] rtBltzal = 5'b10000;
	localparam logic [4:0] rtBgezal = 5'b10001;

	typedef enum logic [3:0] {
		clsRType, clsAddi, clsAddiu, clsSlti, clsSltiu, clsAndi, clsOri,
		clsXori, clsLui, clsMem, clsMtc0, clsMfc0, clsNone
	} aluClassE;

	typedef enum logic [4:0] {
		aluAdd, aluAddu, aluSub, aluSubu, aluAnd, aluOr, aluXor, aluNor,
		aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui, aluPassB, aluNone
	} aluCtrlE;

	typedef enum logic [1:0] {
		dstRd = 2'b00,
		dstRt = 2'b01,
		dstRa = 2'b10
	} regDstE;

	typedef struct packed {
		logic     regWrite;
		regDstE   regDst;
		logic     isImm;		// alu operand B from imm
		logic     signExt;
		logic     memRead;
		logic     memWrite;
		logic     memToReg;
		logic     hiloWen;
		logic     hiloToReg;
		logic     cp0Wen;
		logic     cp0ToReg;
		logic     ri;
		logic     brk;
		logic     syscall;
		logic     eret;
		aluClassE aluClass;
	} ctrlT;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
	} fetchT;

	typedef struct packed {
		logic [31:0] pc;
		ctrlT        ctrl;
		aluCtrlE     aluCtrl;
		logic [31:0] rsData;
		logic [31:0] rtData;
		logic [31:0] imm;
		logic [4:0]  shamt;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  destReg;
	} execT;

endpackage
